/* hw/rf_map_pkg.sv */
// Register map of the shared CPU/VPU register file and its basic types
package rf_map_pkg;

    //////////////////////////////
    // Geometry
    //////////////////////////////
    localparam int data_width = 16;
    localparam int addr_width = 5;
    localparam int num_regs   = 32;

    //////////////////////////////
    // Register map
    //////////////////////////////
    // Plain registers 0 to 21
    localparam int num_gpr     = 22;
    localparam int flags_idx   = 22;
    localparam int ret_obj_idx = 23;
    // Vertex registers 24 to 31, loaded by the VPU
    localparam int vertex_base = 24;
    localparam int num_vertex  = 8;

    // One register word
    typedef logic [data_width-1:0] word_t;

    // Register index
    typedef logic [addr_width-1:0] reg_addr_t;

    // One write enable bit per register
    typedef logic [num_regs-1:0] reg_onehot_t;

endpackage

/* hw/flags_pkg.sv */
// Layout of the flags register, condition bits and accumulated key presses
package flags_pkg;

    import rf_map_pkg::*;

    localparam int key_width  = 5;
    localparam int cond_width = 3;

    // Keys: bit 3 up, 2 down, 1 left, 0 right, 4 spare key
    // Cond: Z, N, V from bit 2 down to bit 0
    typedef struct packed {
        logic [7:0]            spare;
        logic [key_width-1:0]  keys;
        logic [cond_width-1:0] cond;
    } flags_fields_t;

    // Plain data for CPU writes, fields for flag and key updates
    typedef union packed {
        word_t         raw;
        flags_fields_t fields;
    } flags_word_u;

endpackage

/* hw/write_decode.sv */
// Decodes both CPU write addresses into one-hot register write enables
`timescale 1ns/1ns

module write_decode
    import rf_map_pkg::*;
(
    input  reg_addr_t   wrt_addr_0,
    input  logic        we_cpu_0,
    input  reg_addr_t   wrt_addr_1,
    input  logic        we_cpu_1,
    output reg_onehot_t we_sel_0,
    output reg_onehot_t we_sel_1
);

    // Single bit at the addressed register, all clear when disabled
    function automatic reg_onehot_t onehot(input reg_addr_t addr, input logic en);
        reg_onehot_t sel;
        sel = '0;
        if (en) begin
            sel[addr] = 1'b1;
        end
        return sel;
    endfunction

    //////////////////////////////
    // Port 0
    //////////////////////////////
    always_comb begin
        we_sel_0 = onehot(wrt_addr_0, we_cpu_0);
    end

    //////////////////////////////
    // Port 1
    //////////////////////////////
    always_comb begin
        we_sel_1 = onehot(wrt_addr_1, we_cpu_1);
    end

endmodule

/* hw/gpr_bank.sv */
// General purpose registers 0 to 21, written by the two CPU ports
`timescale 1ns/1ns

module gpr_bank
    import rf_map_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [num_gpr-1:0]       we_sel_0,
    input  logic [num_gpr-1:0]       we_sel_1,
    input  word_t                    wrt_data_0,
    input  word_t                    wrt_data_1,
    output word_t [num_gpr-1:0]      gpr_q
);

    //////////////////////////////
    // Register array
    //////////////////////////////
    // Port 0 wins when both ports hit the same register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpr_q <= '0;
        end else begin
            for (int i = 0; i < num_gpr; i++) begin
                if (we_sel_0[i]) begin
                    gpr_q[i] <= wrt_data_0;
                end else if (we_sel_1[i]) begin
                    gpr_q[i] <= wrt_data_1;
                end
            end
        end
    end

endmodule

/* hw/flags_reg.sv */
// Flags register with condition load, key accumulation and CPU write access
`timescale 1ns/1ns

module flags_reg
    import rf_map_pkg::*;
    import flags_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flags_we,
    input  logic [cond_width-1:0] cond_flags,
    input  logic                  keys_we,
    input  logic [key_width-1:0]  keys,
    input  logic                  sel_0,
    input  logic                  sel_1,
    input  word_t                 wrt_data_0,
    input  word_t                 wrt_data_1,
    output word_t                 flags_q
);

    flags_word_u flags_r;

    //////////////////////////////
    // Update priority
    //////////////////////////////
    // Flag strobe, then key strobe, then CPU port 0, then port 1
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flags_r.raw <= '0;
        end else if (flags_we) begin
            flags_r.fields.cond <= cond_flags;
        end else if (keys_we) begin
            // Key presses stick until software clears them
            flags_r.fields.keys <= flags_r.fields.keys | keys;
        end else if (sel_0) begin
            flags_r.raw <= wrt_data_0;
        end else if (sel_1) begin
            flags_r.raw <= wrt_data_1;
        end
    end

    assign flags_q = flags_r.raw;

endmodule

/* hw/vertex_bank.sv */
// Return-object and vertex registers, bulk loaded by the VPU in one cycle
`timescale 1ns/1ns

module vertex_bank
    import rf_map_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                vpu_we,
    input  word_t                               return_obj,
    input  word_t [num_vertex-1:0]              wrt_v,
    input  logic [num_regs-ret_obj_idx-1:0]     we_sel_0,
    input  logic [num_regs-ret_obj_idx-1:0]     we_sel_1,
    input  word_t                               wrt_data_0,
    input  word_t                               wrt_data_1,
    output word_t                               ret_obj_q,
    output word_t [num_vertex-1:0]              vertex_q
);

    // Enable bit 0 is the return object, vertices follow
    localparam int v_ofs = vertex_base - ret_obj_idx;

    //////////////////////////////
    // Return object
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ret_obj_q <= '0;
        end else if (vpu_we) begin
            ret_obj_q <= return_obj;
        end else if (we_sel_0[0]) begin
            ret_obj_q <= wrt_data_0;
        end else if (we_sel_1[0]) begin
            ret_obj_q <= wrt_data_1;
        end
    end

    //////////////////////////////
    // Vertices
    //////////////////////////////
    // A VPU load drops any CPU write in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vertex_q <= '0;
        end else if (vpu_we) begin
            vertex_q <= wrt_v;
        end else begin
            for (int i = 0; i < num_vertex; i++) begin
                if (we_sel_0[i+v_ofs]) begin
                    vertex_q[i] <= wrt_data_0;
                end else if (we_sel_1[i+v_ofs]) begin
                    vertex_q[i] <= wrt_data_1;
                end
            end
        end
    end

endmodule

/* hw/read_mux.sv */
// Two independent combinational read ports over all 32 registers
`timescale 1ns/1ns

module read_mux
    import rf_map_pkg::*;
(
    input  word_t [num_regs-1:0] regs,
    input  reg_addr_t            reg_addr_0,
    input  reg_addr_t            reg_addr_1,
    output word_t                reg_data_0,
    output word_t                reg_data_1
);

    //////////////////////////////
    // Read port 0
    //////////////////////////////
    always_comb begin
        reg_data_0 = regs[reg_addr_0];
    end

    //////////////////////////////
    // Read port 1
    //////////////////////////////
    // Same array, own address, no ordering against port 0
    always_comb begin
        reg_data_1 = regs[reg_addr_1];
    end

endmodule

/* hw/regfile_top.sv */
// Shared CPU/VPU register file with two read ports and two write ports
`timescale 1ns/1ns

module regfile_top
    import rf_map_pkg::*;
    import flags_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    // CPU read side
    input  reg_addr_t             reg_addr_0,
    input  reg_addr_t             reg_addr_1,
    // CPU write side
    input  reg_addr_t             wrt_addr_0,
    input  reg_addr_t             wrt_addr_1,
    input  logic                  we_cpu_0,
    input  logic                  we_cpu_1,
    input  word_t                 wrt_data_0,
    input  word_t                 wrt_data_1,
    // Flags and key presses
    input  logic                  flags_we,
    input  logic [cond_width-1:0] cond_flags,
    input  logic                  keys_we,
    input  logic [key_width-1:0]  keys,
    // VPU bulk load
    input  logic                  vpu_we,
    input  word_t                 return_obj,
    input  word_t [num_vertex-1:0] wrt_v,
    // Outputs
    output word_t                 reg_data_0,
    output word_t                 reg_data_1,
    output word_t                 read_ro,
    output word_t [num_vertex-1:0] read_v
);

    reg_onehot_t            we_sel_0;
    reg_onehot_t            we_sel_1;
    word_t [num_gpr-1:0]    gpr_q;
    word_t                  flags_q;
    word_t [num_regs-1:0]   regs;

    //////////////////////////////
    // Write enables
    //////////////////////////////
    write_decode i_write_decode (
        .wrt_addr_0 (wrt_addr_0),
        .we_cpu_0   (we_cpu_0),
        .wrt_addr_1 (wrt_addr_1),
        .we_cpu_1   (we_cpu_1),
        .we_sel_0   (we_sel_0),
        .we_sel_1   (we_sel_1)
    );

    //////////////////////////////
    // Register banks
    //////////////////////////////
    gpr_bank i_gpr_bank (
        .clk        (clk),
        .rst_n      (rst_n),
        .we_sel_0   (we_sel_0[num_gpr-1:0]),
        .we_sel_1   (we_sel_1[num_gpr-1:0]),
        .wrt_data_0 (wrt_data_0),
        .wrt_data_1 (wrt_data_1),
        .gpr_q      (gpr_q)
    );

    flags_reg i_flags_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .flags_we   (flags_we),
        .cond_flags (cond_flags),
        .keys_we    (keys_we),
        .keys       (keys),
        .sel_0      (we_sel_0[flags_idx]),
        .sel_1      (we_sel_1[flags_idx]),
        .wrt_data_0 (wrt_data_0),
        .wrt_data_1 (wrt_data_1),
        .flags_q    (flags_q)
    );

    // Its outputs go straight to the VPU ports
    vertex_bank i_vertex_bank (
        .clk        (clk),
        .rst_n      (rst_n),
        .vpu_we     (vpu_we),
        .return_obj (return_obj),
        .wrt_v      (wrt_v),
        .we_sel_0   (we_sel_0[num_regs-1:ret_obj_idx]),
        .we_sel_1   (we_sel_1[num_regs-1:ret_obj_idx]),
        .wrt_data_0 (wrt_data_0),
        .wrt_data_1 (wrt_data_1),
        .ret_obj_q  (read_ro),
        .vertex_q   (read_v)
    );

    // Register 0 sits in the lowest word
    assign regs = {read_v, read_ro, flags_q, gpr_q};

    //////////////////////////////
    // Read ports
    //////////////////////////////
    read_mux i_read_mux (
        .regs       (regs),
        .reg_addr_0 (reg_addr_0),
        .reg_addr_1 (reg_addr_1),
        .reg_data_0 (reg_data_0),
        .reg_data_1 (reg_data_1)
    );

endmodule

/* verif/regfile_tb.sv */
// Directed testbench for the shared CPU/VPU register file with a reference model
`timescale 1ns/1ns

module regfile_tb
    import rf_map_pkg::*;
    import flags_pkg::*;
;

    logic                   clk;
    logic                   rst_n;
    reg_addr_t              reg_addr_0;
    reg_addr_t              reg_addr_1;
    reg_addr_t              wrt_addr_0;
    reg_addr_t              wrt_addr_1;
    logic                   we_cpu_0;
    logic                   we_cpu_1;
    word_t                  wrt_data_0;
    word_t                  wrt_data_1;
    logic                   flags_we;
    logic [cond_width-1:0]  cond_flags;
    logic                   keys_we;
    logic [key_width-1:0]   keys;
    logic                   vpu_we;
    word_t                  return_obj;
    word_t [num_vertex-1:0] wrt_v;
    word_t                  reg_data_0;
    word_t                  reg_data_1;
    word_t                  read_ro;
    word_t [num_vertex-1:0] read_v;

    word_t model [num_regs];
    int    errors;
    int    seed_ret;

    regfile_top i_dut (
        .clk(clk), .rst_n(rst_n), .reg_addr_0(reg_addr_0), .reg_addr_1(reg_addr_1),
        .wrt_addr_0(wrt_addr_0), .wrt_addr_1(wrt_addr_1), .we_cpu_0(we_cpu_0),
        .we_cpu_1(we_cpu_1), .wrt_data_0(wrt_data_0), .wrt_data_1(wrt_data_1),
        .flags_we(flags_we), .cond_flags(cond_flags), .keys_we(keys_we), .keys(keys),
        .vpu_we(vpu_we), .return_obj(return_obj), .wrt_v(wrt_v),
        .reg_data_0(reg_data_0), .reg_data_1(reg_data_1), .read_ro(read_ro), .read_v(read_v)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Watchdog against a stuck run
    initial begin
        for (int cyc = 0; cyc < 2000; cyc++) begin
            @(posedge clk);
        end
        $display("Timeout: test sequence did not complete within 2000 cycles");
        $display("Done: errors found");
        $finish;
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////
    // Next state of every register from the inputs present at the coming edge
    task automatic update_model();
        flags_word_u f;
        for (int r = 0; r < num_regs; r++) begin
            if (!rst_n) begin
                model[r] = '0;
            end else if (r == flags_idx && flags_we) begin
                f.raw = model[r];
                f.fields.cond = cond_flags;
                model[r] = f.raw;
            end else if (r == flags_idx && keys_we) begin
                f.raw = model[r];
                f.fields.keys = f.fields.keys | keys;
                model[r] = f.raw;
            end else if (r >= ret_obj_idx && vpu_we) begin
                model[r] = (r == ret_obj_idx) ? return_obj : wrt_v[r-vertex_base];
            end else if (we_cpu_0 && wrt_addr_0 == r) begin
                model[r] = wrt_data_0;
            end else if (we_cpu_1 && wrt_addr_1 == r) begin
                model[r] = wrt_data_1;
            end
        end
    endtask

    task automatic clock_cycle();
        update_model();
        @(posedge clk);
        #2;
    endtask

    task automatic clear_strobes();
        we_cpu_0 = 1'b0;
        we_cpu_1 = 1'b0;
        flags_we = 1'b0;
        keys_we  = 1'b0;
        vpu_we   = 1'b0;
    endtask

    //////////////////////////////
    // Checks
    //////////////////////////////
    task automatic compare_reads(input reg_addr_t a0, input reg_addr_t a1);
        reg_addr_0 = a0;
        reg_addr_1 = a1;
        #1;
        assert (reg_data_0 === model[a0]) else begin
            $display("FAIL reg_data_0 addr %0d: expected %h, got %h", a0, model[a0], reg_data_0);
            errors++;
        end
        assert (reg_data_1 === model[a1]) else begin
            $display("FAIL reg_data_1 addr %0d: expected %h, got %h", a1, model[a1], reg_data_1);
            errors++;
        end
    endtask

    task automatic compare_vpu_outputs();
        assert (read_ro === model[ret_obj_idx]) else begin
            $display("FAIL read_ro: expected %h, got %h", model[ret_obj_idx], read_ro);
            errors++;
        end
        for (int i = 0; i < num_vertex; i++) begin
            assert (read_v[i] === model[vertex_base+i]) else begin
                $display("FAIL read_v[%0d]: expected %h, got %h", i, model[vertex_base+i],
                         read_v[i]);
                errors++;
            end
        end
    endtask

    // Port 1 walks the array backwards
    task automatic sweep_all_regs();
        for (int a = 0; a < num_regs; a++) begin
            compare_reads(reg_addr_t'(a), reg_addr_t'(num_regs - 1 - a));
        end
        compare_vpu_outputs();
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////
    task automatic reset_values();
        rst_n = 1'b0;
        for (int i = 0; i < 8; i++) begin
            clock_cycle();
        end
        rst_n = 1'b1;
        sweep_all_regs();
    endtask

    task automatic dual_write_read();
        reg_addr_t a0;
        reg_addr_t a1;
        for (int n = 0; n < 10; n++) begin
            a0 = reg_addr_t'($urandom_range(num_gpr - 1, 0));
            a1 = reg_addr_t'((a0 + 1 + $urandom_range(num_gpr - 2, 0)) % num_gpr);
            wrt_addr_0 = a0;
            wrt_addr_1 = a1;
            wrt_data_0 = word_t'($urandom);
            wrt_data_1 = word_t'($urandom);
            we_cpu_0   = 1'b1;
            we_cpu_1   = 1'b1;
            clock_cycle();
            clear_strobes();
            compare_reads(a0, a1);
        end
        // Idle cycle with live addresses and data
        wrt_data_0 = word_t'($urandom);
        wrt_data_1 = word_t'($urandom);
        clock_cycle();
        sweep_all_regs();
    endtask

    task automatic port_collision();
        wrt_addr_0 = reg_addr_t'($urandom_range(num_gpr - 1, 0));
        wrt_addr_1 = wrt_addr_0;
        wrt_data_0 = word_t'($urandom);
        wrt_data_1 = ~wrt_data_0;
        we_cpu_0   = 1'b1;
        we_cpu_1   = 1'b1;
        clock_cycle();
        clear_strobes();
        compare_reads(wrt_addr_0, wrt_addr_1);
    endtask

    task automatic flag_updates();
        // Known background in every bit first
        wrt_addr_0 = reg_addr_t'(flags_idx);
        wrt_data_0 = 16'ha5c3;
        we_cpu_0   = 1'b1;
        clock_cycle();
        clear_strobes();
        compare_reads(reg_addr_t'(flags_idx), reg_addr_t'(flags_idx));
        cond_flags = 3'b010;
        flags_we   = 1'b1;
        clock_cycle();
        clear_strobes();
        compare_reads(reg_addr_t'(flags_idx), reg_addr_t'(flags_idx));
        for (int n = 0; n < 4; n++) begin
            keys    = key_width'($urandom);
            keys_we = 1'b1;
            clock_cycle();
            clear_strobes();
            compare_reads(reg_addr_t'(flags_idx), reg_addr_t'(flags_idx));
        end
        // Keys cleared so a stray key update would show
        wrt_data_0 = 16'h5a00;
        we_cpu_0   = 1'b1;
        clock_cycle();
        clear_strobes();
        compare_reads(reg_addr_t'(flags_idx), reg_addr_t'(flags_idx));
        // All three sources at once
        cond_flags = 3'b101;
        keys       = 5'b11111;
        wrt_data_0 = 16'h0000;
        flags_we   = 1'b1;
        keys_we    = 1'b1;
        we_cpu_0   = 1'b1;
        clock_cycle();
        clear_strobes();
        compare_reads(reg_addr_t'(flags_idx), reg_addr_t'(flags_idx));
    endtask

    task automatic vpu_load();
        return_obj = word_t'($urandom);
        for (int i = 0; i < num_vertex; i++) begin
            wrt_v[i] = word_t'($urandom);
        end
        wrt_addr_0 = reg_addr_t'(vertex_base + 3);
        wrt_addr_1 = reg_addr_t'(ret_obj_idx);
        wrt_data_0 = word_t'($urandom);
        wrt_data_1 = word_t'($urandom);
        vpu_we     = 1'b1;
        we_cpu_0   = 1'b1;
        we_cpu_1   = 1'b1;
        clock_cycle();
        clear_strobes();
        compare_vpu_outputs();
        for (int a = ret_obj_idx; a < num_regs; a++) begin
            compare_reads(reg_addr_t'(a), reg_addr_t'(num_regs + ret_obj_idx - 1 - a));
        end
        // Later CPU write to a vertex lands
        wrt_addr_0 = reg_addr_t'(vertex_base + 2);
        wrt_data_0 = word_t'($urandom);
        we_cpu_0   = 1'b1;
        clock_cycle();
        clear_strobes();
        compare_reads(wrt_addr_0, reg_addr_t'(ret_obj_idx));
        compare_vpu_outputs();
    endtask

    initial begin
        errors     = 0;
        seed_ret   = $urandom(20);
        rst_n      = 1'b0;
        reg_addr_0 = '0;
        reg_addr_1 = '0;
        wrt_addr_0 = '0;
        wrt_addr_1 = '0;
        wrt_data_0 = '0;
        wrt_data_1 = '0;
        cond_flags = '0;
        keys       = '0;
        return_obj = '0;
        wrt_v      = '0;
        clear_strobes();
        for (int r = 0; r < num_regs; r++) begin
            model[r] = '0;
        end
        reset_values();
        dual_write_read();
        port_collision();
        flag_updates();
        vpu_load();
        $display("Checks finished with %0d error(s)", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* flist.f */
hw/rf_map_pkg.sv
hw/flags_pkg.sv
hw/write_decode.sv
hw/gpr_bank.sv
hw/flags_reg.sv
hw/vertex_bank.sv
hw/read_mux.sv
hw/regfile_top.sv
verif/regfile_tb.sv

/* Bender.yml */
package:
  name: regfile

sources:
  # Packages first, then RTL bottom up
  - hw/rf_map_pkg.sv
  - hw/flags_pkg.sv
  - hw/write_decode.sv
  - hw/gpr_bank.sv
  - hw/flags_reg.sv
  - hw/vertex_bank.sv
  - hw/read_mux.sv
  - hw/regfile_top.sv
  - target: test
    files:
      - verif/regfile_tb.sv
